//--- verif/icache_patterns.txt
# columns: op (F fetch, S fetch with held response, X flush), address in hex,
# expected miss (1 or 0), cycles with rsp_ready held low (S only)
F 0a40 1 0
F 0a5c 0 0
F 0a48 0 0
F 1240 1 0
F 1244 0 0
F 0a44 1 0
F 0a40 0 0
F 7fe0 1 0
F 7ffc 0 0
F 0060 1 0
F 0064 0 0
X 0000 0 0
F 0a40 1 0
F 7fe4 1 0
F 0060 1 0
S 0a50 0 6
S 2520 1 4
S 2530 0 3
F 7ff0 0 0
F 0068 0 0
F 0a5f 0 0
F 253c 0 0
F 0100 1 0
F 0104 0 0
F 011c 0 0

//--- compile.f
common/icache_pkg.sv
icache/icache_array.sv
icache/icache_ctrl.sv
design/axi_lite_line_fetch.sv
design/icache_top.sv
verif/tb_icache.sv

//--- Makefile
# Verilator build and run for the instruction cache testbench.

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, whatever the simulator's exit status.
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/tb_icache.sv
`timescale 1ns/100ps
`default_nettype none

// testbench for the instruction cache that is driven from a pattern file.
module tb_icache
    import icache_pkg::*;
();

    localparam string PATTERN_FILE  = "verif/icache_patterns.txt";
    localparam int    RESET_CYCLES  = 10;
    localparam int    CYCLES_PER_OP = 40;

    logic        clk;
    logic        rst_n;
    logic        flush;
    logic        req_valid;
    logic        req_ready;
    fetch_addr_t req_addr;
    logic        rsp_valid;
    logic        rsp_ready;
    line_t       rsp_line;
    logic        arvalid;
    logic        arready;
    axil_ar_t    ar;
    logic        rvalid;
    logic        rready;
    axil_r_t     r;

    // operations read from the pattern file.
    logic [7:0]        op_codes[$];
    logic [ADDR_W-1:0] op_addrs[$];
    int                op_misses[$];
    int                op_holds[$];

    // read addresses seen by the memory model during one fetch.
    logic [31:0] ar_log[$];

    logic [31:0] lfsr_state;
    int          cycle_count;
    int          cycle_limit;

    icache_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_addr  (req_addr),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_line  (rsp_line),
        .arvalid   (arvalid),
        .arready   (arready),
        .ar        (ar),
        .rvalid    (rvalid),
        .rready    (rready),
        .r         (r)
    );

    always #5 clk = ~clk;

    // ========================================
    // helpers
    // ========================================

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string what, input line_t actual, input line_t expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s: got %0h, expected %0h", $time, what, actual, expected);
            abort_run();
        end
    endtask

    // a galois lfsr over x^32 + x^22 + x^2 + x + 1 that yields one bit per step.
    function automatic logic next_random_bit();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit)
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        return out_bit;
    endfunction

    function automatic logic [1:0] random_delay();
        logic [1:0] value;
        value[0] = next_random_bit();
        value[1] = next_random_bit();
        return value;
    endfunction

    // every memory word is derived from its own byte address.
    function automatic logic [31:0] memory_word(input logic [31:0] byte_addr);
        return {16'hc0de ^ byte_addr[15:0], byte_addr[15:0]};
    endfunction

    function automatic logic [31:0] line_base(input logic [ADDR_W-1:0] addr);
        return {17'd0, addr[ADDR_W-1:OFFSET_W], 5'd0};
    endfunction

    function automatic line_t expected_line(input logic [ADDR_W-1:0] addr);
        line_t       line;
        logic [31:0] base;
        int          w;
        base = line_base(addr);
        for (w = 0; w < WORDS_PER_LINE; w++)
            line[w*32 +: 32] = memory_word(base + 32'(w * 4));
        return line;
    endfunction

    // ========================================
    // memory model
    // ========================================

    // the model serves one read at a time with random address and data delays.
    always begin : memory_model
        int          wait_cycles;
        logic [31:0] addr;
        @(negedge clk);
        while (rst_n && arvalid) begin
            wait_cycles = int'(random_delay());
            repeat (wait_cycles) @(negedge clk);
            addr = ar.addr;
            ar_log.push_back(addr);
            // an instruction fetch sets the instruction bit of prot.
            check_value("arprot instruction bit", line_t'(ar.prot[2]), line_t'(1));
            check_value("rready while an address is pending", line_t'(rready), line_t'(0));
            arready = 1'b1;
            @(negedge clk);
            arready = 1'b0;
            wait_cycles = int'(random_delay());
            repeat (wait_cycles) @(negedge clk);
            r.data = memory_word(addr);
            r.resp = RESP_OKAY;
            rvalid = 1'b1;
            check_value("rready with read data", line_t'(rready), line_t'(1));
            @(negedge clk);
            rvalid = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    // ========================================
    // operations
    // ========================================

    task automatic read_patterns();
        int          fd;
        int          count;
        string       text;
        logic [7:0]  op;
        logic [ADDR_W-1:0] addr;
        int          miss;
        int          hold;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("could not open the pattern file %s", PATTERN_FILE);
            abort_run();
        end
        while ($fgets(text, fd) != 0) begin
            if (text.len() > 1 && text[0] != "#") begin
                count = $sscanf(text, "%c %h %d %d", op, addr, miss, hold);
                if (count != 4 || (op != "F" && op != "S" && op != "X")) begin
                    $display("the pattern line '%s' could not be understood", text);
                    abort_run();
                end
                op_codes.push_back(op);
                op_addrs.push_back(addr);
                op_misses.push_back(miss);
                op_holds.push_back(hold);
            end
        end
        $fclose(fd);
        if (op_codes.size() == 0) begin
            $display("the pattern file holds no operations");
            abort_run();
        end
    endtask

    task automatic run_flush();
        flush = 1'b1;
        @(negedge clk);
        check_value("req_ready during flush", line_t'(req_ready), line_t'(0));
        flush = 1'b0;
        @(negedge clk);
    endtask

    task automatic run_fetch(input logic [ADDR_W-1:0] addr, input int expect_miss,
                             input int hold);
        line_t       expected;
        line_t       held;
        logic [31:0] base;
        int          latency;
        int          w;
        expected = expected_line(addr);
        base     = line_base(addr);
        ar_log.delete();
        req_addr  = fetch_addr_t'(addr);
        req_valid = 1'b1;
        rsp_ready = (hold == 0);
        while (!req_ready)
            @(negedge clk);
        // the request is taken at the rising edge in between.
        @(negedge clk);
        req_valid = 1'b0;
        latency   = 0;
        while (!rsp_valid) begin
            @(negedge clk);
            latency++;
        end
        if (expect_miss != 0) begin
            check_value("read-address handshakes on a miss", line_t'(ar_log.size()),
                        line_t'(WORDS_PER_LINE));
            for (w = 0; w < WORDS_PER_LINE; w++)
                check_value("read address", line_t'(ar_log[w]), line_t'(base + 32'(w * 4)));
        end else begin
            check_value("read-address handshakes on a hit", line_t'(ar_log.size()), line_t'(0));
            check_value("hit latency in cycles", line_t'(latency), line_t'(1));
        end
        check_value("response line", rsp_line, expected);
        if (hold > 0) begin
            held = rsp_line;
            repeat (hold) begin
                @(negedge clk);
                check_value("rsp_valid while held", line_t'(rsp_valid), line_t'(1));
                check_value("rsp_line while held", rsp_line, held);
                check_value("req_ready while held", line_t'(req_ready), line_t'(0));
            end
            rsp_ready = 1'b1;
        end
        @(negedge clk);
        check_value("rsp_valid after transfer", line_t'(rsp_valid), line_t'(0));
    endtask

    // ========================================
    // main sequence
    // ========================================

    initial begin
        int i;
        clk         = 1'b0;
        rst_n       = 1'b0;
        flush       = 1'b0;
        req_valid   = 1'b0;
        req_addr    = '0;
        rsp_ready   = 1'b1;
        arready     = 1'b0;
        rvalid      = 1'b0;
        r           = '0;
        lfsr_state  = 32'he068_dccc;
        cycle_count = 0;
        cycle_limit = RESET_CYCLES + CYCLES_PER_OP;

        read_patterns();
        cycle_limit = RESET_CYCLES + CYCLES_PER_OP * op_codes.size();

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        check_value("req_ready after reset", line_t'(req_ready), line_t'(1));
        check_value("arvalid after reset", line_t'(arvalid), line_t'(0));
        check_value("rsp_valid after reset", line_t'(rsp_valid), line_t'(0));
        check_value("rready after reset", line_t'(rready), line_t'(0));

        for (i = 0; i < op_codes.size(); i++) begin
            if (op_codes[i] == "X")
                run_flush();
            else if (op_codes[i] == "S")
                run_fetch(op_addrs[i], op_misses[i], op_holds[i]);
            else
                run_fetch(op_addrs[i], op_misses[i], 0);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/icache_top.sv
`timescale 1ns/100ps
`default_nettype none

// 512-byte direct-mapped instruction cache with an AXI4-Lite refill port.
module icache_top
    import icache_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire              flush,

    // fetch side.
    input  wire              req_valid,
    output logic             req_ready,
    input  wire fetch_addr_t req_addr,
    output logic             rsp_valid,
    input  wire              rsp_ready,
    output line_t            rsp_line,

    // memory side, read channels only.
    output logic             arvalid,
    input  wire              arready,
    output axil_ar_t         ar,
    input  wire              rvalid,
    output logic             rready,
    input  wire axil_r_t     r
);

    index_t      rd_index;
    tag_t        tag_rd;
    line_t       line_rd;
    logic        wr_en;
    index_t      wr_index;
    tag_t        wr_tag;
    line_t       wr_line;
    logic        fill_start;
    fetch_addr_t fill_base;
    logic        fill_done;
    line_t       fill_line;

    icache_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_addr   (req_addr),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_line   (rsp_line),
        .rd_index   (rd_index),
        .tag_rd     (tag_rd),
        .line_rd    (line_rd),
        .wr_en      (wr_en),
        .wr_index   (wr_index),
        .wr_tag     (wr_tag),
        .wr_line    (wr_line),
        .fill_start (fill_start),
        .fill_base  (fill_base),
        .fill_done  (fill_done),
        .fill_line  (fill_line)
    );

    // both stores share the index and the write strobe.
    icache_array #(.entry_t(tag_t)) u_tag_store (
        .clk      (clk),
        .rd_index (rd_index),
        .rd_entry (tag_rd),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_entry (wr_tag)
    );

    icache_array #(.entry_t(line_t)) u_data_store (
        .clk      (clk),
        .rd_index (rd_index),
        .rd_entry (line_rd),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_entry (wr_line)
    );

    axi_lite_line_fetch u_line_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .fill_start (fill_start),
        .fill_base  (fill_base),
        .fill_done  (fill_done),
        .fill_line  (fill_line),
        .arvalid    (arvalid),
        .arready    (arready),
        .ar         (ar),
        .rvalid     (rvalid),
        .rready     (rready),
        .r          (r)
    );

endmodule

`default_nettype wire

//--- design/axi_lite_line_fetch.sv
`timescale 1ns/100ps
`default_nettype none

// reads one cache line as eight AXI4-Lite word reads, one at a time.
module axi_lite_line_fetch
    import icache_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,

    // line request from the controller.
    input  wire              fill_start,
    input  wire fetch_addr_t fill_base,
    output logic             fill_done,
    output line_t            fill_line,

    // AXI4-Lite read channels.
    output logic             arvalid,
    input  wire              arready,
    output axil_ar_t         ar,
    input  wire              rvalid,
    output logic             rready,
    input  wire axil_r_t     r
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_DONE
    } state_t;

    state_t                              state_q;
    logic [$clog2(WORDS_PER_LINE)-1:0]   beat_q;
    tag_t                                base_tag_q;
    index_t                              base_index_q;
    line_t                               line_q;

    // ========================================
    // sequencing
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    beat_q <= '0;
                    if (fill_start)
                        state_q <= ST_ADDR;
                end
                ST_ADDR: begin
                    if (arready)
                        state_q <= ST_DATA;
                end
                ST_DATA: begin
                    if (rvalid) begin
                        beat_q  <= beat_q + 1'b1;
                        state_q <= (int'(beat_q) == WORDS_PER_LINE - 1) ? ST_DONE : ST_ADDR;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // line base and the assembled words.
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && fill_start) begin
            base_tag_q   <= fill_base.tag;
            base_index_q <= fill_base.index;
        end
        if (state_q == ST_DATA && rvalid)
            line_q[beat_q*AXI_DATA_W +: AXI_DATA_W] <= r.data;
    end

    // ========================================
    // outputs
    // ========================================

    assign arvalid = (state_q == ST_ADDR);
    assign rready  = (state_q == ST_DATA);

    // prot marks an instruction access.
    assign ar.addr = {{(AXI_ADDR_W-ADDR_W){1'b0}}, base_tag_q, base_index_q, beat_q, 2'b00};
    assign ar.prot = 3'b100;

    assign fill_done = (state_q == ST_DONE);
    assign fill_line = line_q;

    // ========================================
    // checks
    // ========================================

    ar_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(ar));

    // memory never reports an error for instruction fetches.
    r_okay_a: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid |-> r.resp == RESP_OKAY);

endmodule

`default_nettype wire

//--- icache/icache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

// lookup and fill control for the direct-mapped instruction cache.
module icache_ctrl
    import icache_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire              flush,

    // fetch request.
    input  wire              req_valid,
    output logic             req_ready,
    input  wire fetch_addr_t req_addr,

    // fetch response.
    output logic             rsp_valid,
    input  wire              rsp_ready,
    output line_t            rsp_line,

    // array ports.
    output index_t           rd_index,
    input  wire tag_t        tag_rd,
    input  wire line_t       line_rd,
    output logic             wr_en,
    output index_t           wr_index,
    output tag_t             wr_tag,
    output line_t            wr_line,

    // line fetcher.
    output logic             fill_start,
    output fetch_addr_t      fill_base,
    input  wire              fill_done,
    input  wire line_t       fill_line
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_FILL,
        ST_REPLAY,
        ST_RESPOND
    } state_t;

    state_t               state_q;
    state_t               state_d;
    logic [NUM_LINES-1:0] valid_q;
    fetch_addr_t          req_q;
    logic                 hit;

    // ========================================
    // hit detection
    // ========================================

    // the tag only counts when the entry holds a line.
    assign hit = valid_q[req_q.index] ? (tag_rd == req_q.tag) : 1'b0;

    // ========================================
    // state machine
    // ========================================

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_valid && req_ready)
                    state_d = ST_LOOKUP;
            end
            ST_LOOKUP: begin
                state_d = hit ? ST_RESPOND : ST_FILL;
            end
            ST_FILL: begin
                if (fill_done)
                    state_d = ST_REPLAY;
            end
            // the arrays were written last edge, so read them once more.
            ST_REPLAY: begin
                state_d = ST_RESPOND;
            end
            ST_RESPOND: begin
                if (rsp_ready)
                    state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_IDLE && flush)
                valid_q <= '0;
            else if (wr_en)
                valid_q[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready)
            req_q <= req_addr;
    end

    // ========================================
    // outputs
    // ========================================

    assign req_ready = (state_q == ST_IDLE) && !flush;

    // in idle the incoming index goes straight to the arrays.
    assign rd_index = (state_q == ST_IDLE) ? req_addr.index : req_q.index;

    // the held index keeps the array output steady while the response waits.
    assign rsp_valid = (state_q == ST_RESPOND);
    assign rsp_line  = line_rd;

    assign wr_en    = (state_q == ST_FILL) && fill_done;
    assign wr_index = req_q.index;
    assign wr_tag   = req_q.tag;
    assign wr_line  = fill_line;

    assign fill_start = (state_q == ST_LOOKUP) && !hit;
    assign fill_base  = '{tag: req_q.tag, index: req_q.index, offset: '0};

    // ========================================
    // checks
    // ========================================

    rsp_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_line));

    // the fetcher only completes a line that this FSM asked for.
    fill_done_in_fill_a: assert property (@(posedge clk) disable iff (!rst_n)
        fill_done |-> state_q == ST_FILL);

endmodule

`default_nettype wire

//--- icache/icache_array.sv
`timescale 1ns/100ps
`default_nettype none

// one storage array of the cache, indexed by line.
// the tag store and the data store are both built from this module.
module icache_array
    import icache_pkg::*;
#(
    parameter type entry_t = tag_t
) (
    input  wire            clk,

    // read port, data is valid one cycle after the index.
    input  wire index_t    rd_index,
    output entry_t         rd_entry,

    // write port.
    input  wire            wr_en,
    input  wire index_t    wr_index,
    input  wire entry_t    wr_entry
);

    entry_t mem [NUM_LINES];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_index] <= wr_entry;
        end
    end

    // a read that collides with a write to the same index sees the old entry.
    always_ff @(posedge clk) begin
        rd_entry <= mem[rd_index];
    end

endmodule

`default_nettype wire

//--- common/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // ========================================
    // geometry
    // ========================================

    // 15-bit physical address, split as tag (14..9), index (8..5), offset (4..0).
    localparam int ADDR_W   = 15;
    localparam int TAG_W    = 6;
    localparam int INDEX_W  = 4;
    localparam int OFFSET_W = 5;

    // sixteen lines of 32 bytes give the 512-byte store.
    localparam int NUM_LINES      = 16;
    localparam int LINE_W         = 256;
    localparam int WORDS_PER_LINE = 8;

    // ========================================
    // memory bus
    // ========================================

    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // ========================================
    // types
    // ========================================

    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    // word 0 of the line sits in bits 31..0.
    typedef logic [LINE_W-1:0] line_t;

    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } fetch_addr_t;

    // read-address channel payload.
    typedef struct packed {
        logic [AXI_ADDR_W-1:0] addr;
        logic [2:0]            prot;
    } axil_ar_t;

    // read-data channel payload.
    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [1:0]            resp;
    } axil_r_t;

endpackage

`default_nettype wire
